//--- run.sh
#!/bin/sh
# build the pipeline testbench with Verilator, run it, decide on the log contents
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module pipe_tb -f src.f -o pipe_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/pipe_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0

//--- source/execute_stage.sv
/*
 * execute stage: decode through the instruction union, M-to-E forwarding,
 * ALU and address adder, BEQ compare, branch and jump target, E/M register
 */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire logic                 CLK,
    input  wire logic                 rst,
    input  wire pipe_pkg::hazard_out_t hz,
    input  wire pipe_pkg::fe_reg_t     fe,
    input  wire pipe_pkg::word_t       rdata1,
    input  wire pipe_pkg::word_t       rdata2,
    input  wire pipe_pkg::word_t       fwd_data,
    output logic [4:0]                rs1,
    output logic [4:0]                rs2,
    output pipe_pkg::em_reg_t         em,
    output pipe_pkg::word_t           redirect_pc,
    output logic                      branch_taken,
    output logic                      jump,
    output logic                      illegal
);

    pipe_pkg::insn_u   insn;
    pipe_pkg::word_t   op_a;
    pipe_pkg::word_t   op_b;
    pipe_pkg::word_t   imm_i;
    pipe_pkg::word_t   imm_s;
    pipe_pkg::word_t   imm_b;
    pipe_pkg::word_t   imm_j;
    pipe_pkg::em_reg_t em_next;
    logic fwd_a;
    logic fwd_b;
    logic keep; // instruction moves on into M

    assign insn = fe.insn;
    assign rs1  = insn.r_view.rs1;
    assign rs2  = insn.r_view.rs2;

    // immediates; S and B take their low bits from the rd field
    assign imm_i = {{20{insn.i_view.imm[11]}}, insn.i_view.imm};
    assign imm_s = {{20{insn.r_view.funct7[6]}}, insn.r_view.funct7, insn.r_view.rd};
    assign imm_b = {{20{insn.r_view.funct7[6]}}, insn.r_view.rd[0],
                    insn.r_view.funct7[5:0], insn.r_view.rd[4:1], 1'b0};
    assign imm_j = {{12{insn.i_view.imm[11]}}, insn.i_view.rs1, insn.i_view.funct3,
                    insn.i_view.imm[0], insn.i_view.imm[10:1], 1'b0};

    // loads in M are not forwarded, the hazard unit stalls for them
    assign fwd_a = em.valid && em.reg_write && !em.dren && (em.rd == rs1);
    assign fwd_b = em.valid && em.reg_write && !em.dren && (em.rd == rs2);
    assign op_a  = fwd_a ? fwd_data : rdata1;
    assign op_b  = fwd_b ? fwd_data : rdata2;

    assign redirect_pc = fe.pc + (jump ? imm_j : imm_b); // one target adder
    assign keep        = fe.valid && !hz.em_flush;

    always_comb begin
        em_next            = '0;
        em_next.pc         = fe.pc;
        em_next.rd         = insn.r_view.rd;
        em_next.store_data = op_b;
        em_next.alu_result = op_a + op_b;
        branch_taken       = 1'b0;
        jump               = 1'b0;
        illegal            = 1'b0;
        case (insn.r_view.opcode)
            pipe_pkg::OP: begin
                em_next.reg_write = 1'b1;
                if (insn.r_view.funct3 != 3'b000)
                    illegal = 1'b1;
                else if (insn.r_view.funct7 == 7'h20)
                    em_next.alu_result = op_a - op_b; // sub
                else if (insn.r_view.funct7 != 7'h00)
                    illegal = 1'b1;
            end
            pipe_pkg::OP_IMM: begin
                em_next.reg_write  = 1'b1;
                em_next.alu_result = op_a + imm_i;
                illegal            = (insn.i_view.funct3 != 3'b000); // addi only
            end
            pipe_pkg::LOAD: begin
                em_next.reg_write  = 1'b1;
                em_next.dren       = 1'b1;
                em_next.alu_result = op_a + imm_i;
                illegal            = (insn.i_view.funct3 != 3'b010); // lw only
            end
            pipe_pkg::STORE: begin
                em_next.dwen       = 1'b1;
                em_next.alu_result = op_a + imm_s;
                illegal            = (insn.r_view.funct3 != 3'b010); // sw only
            end
            pipe_pkg::BRANCH: begin
                illegal      = (insn.r_view.funct3 != 3'b000); // beq only
                branch_taken = !illegal && (op_a == op_b);
            end
            pipe_pkg::JAL: begin
                jump               = 1'b1;
                em_next.reg_write  = 1'b1;
                em_next.alu_result = fe.pc + 32'd4; // link value
            end
            default: illegal = 1'b1;
        endcase
        // status only means something for a valid instruction
        branch_taken      = branch_taken & fe.valid;
        jump              = jump & fe.valid;
        illegal           = illegal & fe.valid;
        em_next.valid     = keep;
        em_next.reg_write = em_next.reg_write & keep & (em_next.rd != 5'd0);
        em_next.dren      = em_next.dren & keep;
        em_next.dwen      = em_next.dwen & keep;
    end

    // a taken branch or jump goes on into M, only the younger word in F is squashed
    always_ff @(posedge CLK) begin
        if (rst) begin
            em.valid     <= 1'b0;
            em.reg_write <= 1'b0;
            em.dren      <= 1'b0;
            em.dwen      <= 1'b0;
        end else if (!hz.em_stall) begin
            em <= em_next;
        end
    end

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
/*
 * fetch stage: pc register, four-phase instruction memory handshake
 * with discard of words fetched on a stale path, and the F/E register
 */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_cfg.svh"

module fetch_stage (
    input  wire logic                 CLK,
    input  wire logic                 rst,
    input  wire pipe_pkg::hazard_out_t hz,
    input  wire pipe_pkg::word_t       redirect_pc,
    input  wire logic                 imem_ack,
    input  wire pipe_pkg::word_t       imem_rdata,
    output logic                      imem_req,
    output pipe_pkg::word_t           imem_addr,
    output pipe_pkg::fe_reg_t         fe,
    output logic                      i_busy
);

    pipe_pkg::word_t pc_q;
    logic discard_q;   // outstanding request belongs to a squashed path
    logic redirect;
    logic fetch_done;  // ack seen for the open request
    logic fetch_valid;

    assign redirect    = hz.npc_sel | hz.trap_redirect;
    assign fetch_done  = imem_req & imem_ack;
    assign fetch_valid = fetch_done & ~discard_q;
    assign i_busy      = ~fetch_valid; // no usable word this cycle

    // next pc; the trap vector wins over a branch target
    always_ff @(posedge CLK) begin
        if (rst) begin
            pc_q <= `PIPE_RESET_PC;
        end else if (hz.pc_en) begin
            if (hz.trap_redirect)
                pc_q <= `PIPE_TRAP_VEC;
            else if (hz.npc_sel)
                pc_q <= redirect_pc;
            else
                pc_q <= pc_q + 32'd4;
        end
    end

    // req drops once the word is taken or thrown away
    // a valid word under fe_stall keeps req and ack high, so the memory holds the data
    always_ff @(posedge CLK) begin
        if (rst) begin
            imem_req  <= 1'b0;
            discard_q <= 1'b0;
        end else begin
            if (imem_req) begin
                if (imem_ack && (discard_q || hz.pc_en))
                    imem_req <= 1'b0;
            end else if (!imem_ack && !redirect) begin
                imem_req <= 1'b1; // previous ack gone, pc settled
            end
            if (fetch_done)
                discard_q <= 1'b0;
            else if (redirect && imem_req)
                discard_q <= 1'b1; // let the transfer finish, drop its word
        end
    end

    // address is captured while idle and held for the whole transfer
    always_ff @(posedge CLK) begin
        if (!imem_req)
            imem_addr <= pc_q;
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            fe.valid <= 1'b0;
        end else if (!hz.fe_stall || hz.fe_flush) begin
            fe.valid <= fetch_valid & ~hz.fe_flush; // bubble on flush or late fetch
            fe.pc    <= imem_addr;
            fe.insn  <= pipe_pkg::insn_u'(imem_rdata);
        end
    end

    // the memory may sample the address at any cycle of the transfer
    a_imem_addr_stable: assert property (@(posedge CLK) disable iff (rst)
        imem_req |=> !imem_req || $stable(imem_addr))
        else $error("imem_addr changed while imem_req was high");

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
/*
 * hazard control: load-use and memory wait stalls, flushes,
 * branch and trap redirect, trap cause and epc selection
 */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  wire pipe_pkg::hazard_in_t hin,
    output pipe_pkg::hazard_out_t     hz,
    output logic                      trap_valid,
    output pipe_pkg::trap_cause_e     trap_cause,
    output pipe_pkg::word_t           trap_epc
);

    logic rs1_match;
    logic rs2_match;
    logic load_use;
    logic wait_dmem;
    logic wait_imem;
    logic e_free;      // E may act on its instruction this cycle
    logic branch_jump;
    logic trap_e;
    logic trap_m;
    logic trap;

    assign rs1_match = (hin.rs1_e == hin.rd_m) && (hin.rd_m != 5'd0);
    assign rs2_match = (hin.rs2_e == hin.rd_m) && (hin.rd_m != 5'd0);

    // a misaligned load never writes, no need to wait for it
    assign load_use  = hin.valid_m && hin.dren_m && hin.reg_write_m && !hin.misaligned_m
                     && hin.valid_e && (rs1_match || rs2_match);
    assign trap_m    = hin.valid_m && hin.misaligned_m;
    assign wait_dmem = hin.d_busy && !hz.suppress_data;
    assign wait_imem = hin.i_busy;

    // E events wait until M drains and operands are good; an M trap is older
    assign e_free      = !wait_dmem && !load_use && !trap_m;
    assign branch_jump = hin.valid_e && (hin.branch_taken || hin.jump) && e_free;
    assign trap_e      = hin.valid_e && hin.illegal_e && e_free;
    assign trap        = trap_m || trap_e;

    assign hz.suppress_data = trap_m;
    assign hz.npc_sel       = branch_jump;
    assign hz.trap_redirect = trap;

    assign hz.em_stall = wait_dmem; // slow dmem holds everyone
    assign hz.em_flush = trap                             // faulting and younger squashed
                       || (hz.fe_stall && !hz.em_stall);  // bubble while E waits on a load
    assign hz.fe_stall = hz.em_stall || load_use;
    assign hz.fe_flush = branch_jump || trap
                       || (wait_imem && !hz.fe_stall);    // fetch lagging, E moves
    assign hz.pc_en    = (!hz.fe_stall && !wait_imem) || branch_jump || trap;

    assign trap_valid = trap;
    assign trap_cause = trap_m ? pipe_pkg::MISALIGNED_ADDR : pipe_pkg::ILLEGAL_INSN;
    assign trap_epc   = trap_m ? hin.pc_m : hin.pc_e;

    // stall of F/E only stands beside a flush while M is held
    always_comb begin
        if (!hz.em_stall) begin
            a_fe_stall_flush: assert final (!(hz.fe_flush && hz.fe_stall))
                else $error("F/E stalled and flushed together with M moving");
        end
    end

endmodule

`default_nettype wire

//--- source/mem_stage.sv
/*
 * memory and writeback stage: four-phase data memory handshake,
 * misaligned address check, forwarding value and writeback port
 */
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire logic                 CLK,
    input  wire logic                 rst,
    input  wire pipe_pkg::hazard_out_t hz,
    input  wire pipe_pkg::em_reg_t     em,
    input  wire logic                 dmem_ack,
    input  wire pipe_pkg::word_t       dmem_rdata,
    output logic                      dmem_req,
    output logic                      dmem_we,
    output pipe_pkg::word_t           dmem_addr,
    output pipe_pkg::word_t           dmem_wdata,
    output logic                      d_busy,
    output logic                      misaligned,
    output pipe_pkg::word_t           fwd_data,
    output logic                      wb_valid,
    output logic [4:0]                wb_rd,
    output pipe_pkg::word_t           wb_data
);

    logic access; // lw or sw sitting in M
    logic done;   // ack sampled for the open request

    assign access     = em.valid && (em.dren || em.dwen);
    assign misaligned = access && (em.alu_result[1:0] != 2'b00);
    assign done       = dmem_req && dmem_ack;
    assign d_busy     = access && !done; // misaligned ones held off by suppress_data

    // E/M is held while busy, so address and data stay put during the transfer
    assign dmem_we    = em.dwen;
    assign dmem_addr  = em.alu_result;
    assign dmem_wdata = em.store_data;

    always_ff @(posedge CLK) begin
        if (rst) begin
            dmem_req <= 1'b0;
        end else if (dmem_req) begin
            if (dmem_ack)
                dmem_req <= 1'b0; // M moves on at this same edge
        end else if (d_busy && !dmem_ack && !hz.suppress_data) begin
            dmem_req <= 1'b1;
        end
    end

    // ALU results retire in their M cycle, loads at the ack edge
    assign wb_valid = em.valid && em.reg_write && !misaligned && (!em.dren || done);
    assign wb_rd    = em.rd;
    assign wb_data  = em.dren ? dmem_rdata : em.alu_result;
    assign fwd_data = em.alu_result; // only ALU results forward to E

    a_dmem_req_after_ack: assert property (@(posedge CLK) disable iff (rst)
        (!dmem_req && dmem_ack) |=> !dmem_req)
        else $error("dmem_req raised before dmem_ack dropped");

endmodule

`default_nettype wire

//--- source/pipe_cfg.svh
/*
 * configuration macros for the three-stage pipeline
 * reset pc, trap vector and register count
 */
`ifndef PIPE_CFG_SVH
`define PIPE_CFG_SVH

`define PIPE_RESET_PC 32'h0000_0000 // first fetch address
`define PIPE_TRAP_VEC 32'h0000_0100 // fetch target after any trap
`define PIPE_NREGS    32            // integer register count, x0 included

`endif

//--- source/pipe_pkg.sv
/*
 * shared types of the pipeline: data word, opcodes, trap causes,
 * instruction word union, F/E and E/M registers, hazard status and control
 */
`default_nettype none

package pipe_pkg;

    typedef logic [31:0] word_t;

    // only the opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ILLEGAL_INSN    = 4'd2, // same codes as mcause
        MISALIGNED_ADDR = 4'd4
    } trap_cause_e;

    // one instruction word, seen as R-type or as I-type
    // S, B and J immediates are pieced together from both views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    opcode;
        } r_view;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     opcode;
        } i_view;
    } insn_u;

    typedef struct packed {
        logic  valid;
        word_t pc;
        insn_u insn;
    } fe_reg_t;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        logic [4:0] rd;
        logic       reg_write;
        logic       dren;
        logic       dwen;
        word_t      alu_result; // data address for loads and stores
        word_t      store_data;
    } em_reg_t;

    // status gathered from the stages
    typedef struct packed {
        logic [4:0] rs1_e;
        logic [4:0] rs2_e;
        logic [4:0] rd_m;
        logic       reg_write_m;
        logic       dren_m;
        logic       i_busy;
        logic       d_busy;
        logic       branch_taken;
        logic       jump;
        logic       illegal_e;
        logic       misaligned_m;
        logic       valid_e;
        logic       valid_m;
        word_t      pc_e;
        word_t      pc_m;
    } hazard_in_t;

    // control returned to the stages
    typedef struct packed {
        logic pc_en;
        logic npc_sel;       // take the branch or jump target
        logic trap_redirect; // take the trap vector
        logic fe_stall;
        logic fe_flush;
        logic em_stall;
        logic em_flush;
        logic suppress_data; // keep dmem req low for a faulting access
    } hazard_out_t;

endpackage

`default_nettype wire

//--- source/pipe_top.sv
/*
 * pipeline top level
 * fetch, execute, register file, memory stage and hazard unit
 */
`timescale 1ns/1ps
`default_nettype none

module pipe_top (
    input  wire logic             CLK,
    input  wire logic             rst,
    output logic                  imem_req,
    output pipe_pkg::word_t       imem_addr,
    input  wire logic             imem_ack,
    input  wire pipe_pkg::word_t  imem_rdata,
    output logic                  dmem_req,
    output logic                  dmem_we,
    output pipe_pkg::word_t       dmem_addr,
    output pipe_pkg::word_t       dmem_wdata,
    input  wire logic             dmem_ack,
    input  wire pipe_pkg::word_t  dmem_rdata,
    output logic                  wb_valid,
    output logic [4:0]            wb_rd,
    output pipe_pkg::word_t       wb_data,
    output logic                  trap_valid,
    output pipe_pkg::trap_cause_e trap_cause,
    output pipe_pkg::word_t       trap_epc
);

    pipe_pkg::fe_reg_t     fe;
    pipe_pkg::em_reg_t     em;
    pipe_pkg::hazard_in_t  hin;
    pipe_pkg::hazard_out_t hz;
    pipe_pkg::word_t       redirect_pc;
    pipe_pkg::word_t       rdata1;
    pipe_pkg::word_t       rdata2;
    pipe_pkg::word_t       fwd_data;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic                  i_busy;
    logic                  d_busy;
    logic                  branch_taken;
    logic                  jump;
    logic                  illegal;
    logic                  misaligned;

    assign hin = '{rs1_e: rs1, rs2_e: rs2, rd_m: em.rd, reg_write_m: em.reg_write,
                   dren_m: em.dren, i_busy: i_busy, d_busy: d_busy,
                   branch_taken: branch_taken, jump: jump, illegal_e: illegal,
                   misaligned_m: misaligned, valid_e: fe.valid, valid_m: em.valid,
                   pc_e: fe.pc, pc_m: em.pc};

    fetch_stage u_fetch (
        .CLK, .rst, .hz, .redirect_pc, .imem_ack, .imem_rdata,
        .imem_req, .imem_addr, .fe, .i_busy
    );

    execute_stage u_execute (
        .CLK, .rst, .hz, .fe, .rdata1, .rdata2, .fwd_data,
        .rs1, .rs2, .em, .redirect_pc, .branch_taken, .jump, .illegal
    );

    reg_file u_reg_file (
        .CLK, .rst, .rs1, .rs2,
        .we     (wb_valid),
        .wd_rd  (wb_rd),
        .wdata  (wb_data),
        .rdata1, .rdata2
    );

    mem_stage u_mem (
        .CLK, .rst, .hz, .em, .dmem_ack, .dmem_rdata,
        .dmem_req, .dmem_we, .dmem_addr, .dmem_wdata,
        .d_busy, .misaligned, .fwd_data, .wb_valid, .wb_rd, .wb_data
    );

    hazard_unit u_hazard (
        .hin, .hz, .trap_valid, .trap_cause, .trap_epc
    );

endmodule

`default_nettype wire

//--- source/reg_file.sv
/*
 * integer register file, two read ports and one write port
 * x0 reads as zero, a write in the same cycle is bypassed to the reads
 */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_cfg.svh"

module reg_file (
    input  wire logic            CLK,
    input  wire logic            rst,
    input  wire logic [4:0]      rs1,
    input  wire logic [4:0]      rs2,
    input  wire logic            we,
    input  wire logic [4:0]      wd_rd,
    input  wire pipe_pkg::word_t wdata,
    output pipe_pkg::word_t      rdata1,
    output pipe_pkg::word_t      rdata2
);

    pipe_pkg::word_t regs [`PIPE_NREGS];
    logic wr_en;

    assign wr_en = we && !rst && (wd_rd != 5'd0); // x0 never written

    always_ff @(posedge CLK) begin
        if (wr_en)
            regs[wd_rd] <= wdata;
    end

    assign rdata1 = (rs1 == 5'd0) ? '0 : (wr_en && wd_rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : (wr_en && wd_rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/pipe_pkg.sv
source/fetch_stage.sv
source/execute_stage.sv
source/reg_file.sv
source/mem_stage.sv
source/hazard_unit.sv
source/pipe_top.sv
verification/clock_gen.sv
verification/pipe_tb.sv

//--- verification/clock_gen.sv
/*
 * testbench clock and synchronous reset generator
 */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD       = 40, // ns
    parameter int RESET_CYCLES = 4
) (
    output logic CLK,
    output logic rst
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    // released shortly after a rising edge, as all other DUT inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        #2 rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verification/pipe_patterns.txt
// index = imem byte address / 4 up to 0x7f, data image from 0x80, events from 0x90
// event pair: kind (1000_00rr writeback of rd, 2000_000c trap cause) then value or epc
@00
00500093 00708113 002081b3 40118233  // 0x00 addi x1, addi x2, add x3, sub x4
01000293 0002a303 001303b3 0072a223  // 0x10 addi x5 base, lw x6, add x7 load use, sw x7
0042a403 008404b3 00108663 00100513  // 0x20 lw x8, add x9, beq taken, squashed
00200513 00c005ef 00300613 00400613  // 0x30 squashed, jal x11, squashed, squashed
00208463 00000a13 ffffffff 00100693  // 0x40 beq not taken, clear x20, illegal, squashed
@18
ffe20693 0022a703 00900793           // 0x60 addi x13, misaligned lw, squashed
@40
001a0a13 00100a93 015a0463 0740006f f51ff06f  // 0x100 count traps, resume at 0x60 or end
@60
0000006f                             // 0x180 idle loop
@84
12345678                             // dmem word at 0x10
@90
10000001 00000005
10000002 0000000c
10000003 00000011
10000004 0000000c
10000005 00000010
10000006 12345678
10000007 1234567d
10000008 1234567d
10000009 2468acfa
1000000b 00000038
10000014 00000000
20000002 00000048
10000014 00000001
10000015 00000001
1000000d 0000000a
20000004 00000064
10000014 00000002
10000015 00000001
00000000 00000000

//--- verification/pipe_tb.sv
/*
 * pipeline testbench: instruction and data memory models with random
 * four-phase ack delays, pattern file loading, retirement and trap trace check
 */
`timescale 1ns/1ps
`default_nettype none
`include "pipe_cfg.svh"

module pipe_tb;

    localparam int DMEM_BASE     = 128; // pattern index of the data image
    localparam int EV_BASE       = 144; // pattern index of the first expected event
    localparam int MAX_EVENTS    = 55;
    localparam int EVENT_TIMEOUT = 200; // cycles allowed between two events
    localparam int DRAIN_CYCLES  = 50;
    localparam logic [31:0] IMEM_BYTES = 32'h200;
    localparam logic [31:0] DMEM_BYTES = 32'h40;

    logic                  CLK;
    logic                  rst;
    logic                  imem_req;
    pipe_pkg::word_t       imem_addr;
    logic                  imem_ack   = 1'b0;
    pipe_pkg::word_t       imem_rdata = '0;
    logic                  dmem_req;
    logic                  dmem_we;
    pipe_pkg::word_t       dmem_addr;
    pipe_pkg::word_t       dmem_wdata;
    logic                  dmem_ack   = 1'b0;
    pipe_pkg::word_t       dmem_rdata = '0;
    logic                  wb_valid;
    logic [4:0]            wb_rd;
    pipe_pkg::word_t       wb_data;
    logic                  trap_valid;
    pipe_pkg::trap_cause_e trap_cause;
    pipe_pkg::word_t       trap_epc;

    logic [31:0] pat [0:255];  // imem words, data image, expected events
    logic [31:0] dmem [0:15];  // data memory model, 64 bytes
    logic [63:0] obs_q [$];    // observed events, kind word and value
    integer      seed        = 32'h33cfe171;
    int          i_delay     = -1; // cycles left before imem ack, -1 when idle
    int          d_delay     = -1;
    logic        fetch_seen  = 1'b0;
    int          error_count = 0;
    int          ev;
    int          cycles;
    logic [63:0] got;

    clock_gen #(.PERIOD(40), .RESET_CYCLES(4)) u_clk (.CLK, .rst);

    pipe_top UUT (
        .CLK, .rst,
        .imem_req, .imem_addr, .imem_ack, .imem_rdata,
        .dmem_req, .dmem_we, .dmem_addr, .dmem_wdata, .dmem_ack, .dmem_rdata,
        .wb_valid, .wb_rd, .wb_data,
        .trap_valid, .trap_cause, .trap_epc
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            abort_run("first mismatch ends the run");
        end
    endtask

    // both memories in one block so the random draws keep a fixed order
    always @(posedge CLK) begin
        #2;
        if (rst) begin
            imem_ack = 1'b0;
            dmem_ack = 1'b0;
            i_delay  = -1;
            d_delay  = -1;
        end else begin
            if (imem_ack) begin
                if (!imem_req)
                    imem_ack = 1'b0; // req gone, close the handshake
            end else if (imem_req) begin
                if (i_delay < 0) begin
                    if (!fetch_seen)
                        check_value("first fetch address", `PIPE_RESET_PC, imem_addr);
                    fetch_seen = 1'b1;
                    check_value("imem address alignment", 32'd0, {30'd0, imem_addr[1:0]});
                    if (imem_addr >= IMEM_BYTES)
                        abort_run("instruction fetch outside the program memory");
                    i_delay = int'($unsigned($random(seed)) % 4);
                end
                if (i_delay == 0) begin
                    imem_rdata = pat[{1'b0, imem_addr[8:2]}];
                    imem_ack   = 1'b1;
                end
                i_delay--; // ends at -1 once acked
            end
            if (dmem_ack) begin
                if (!dmem_req)
                    dmem_ack = 1'b0;
            end else if (dmem_req) begin
                if (d_delay < 0) begin
                    // a misaligned access must never reach the bus
                    check_value("dmem address alignment", 32'd0, {30'd0, dmem_addr[1:0]});
                    if (dmem_addr >= DMEM_BYTES)
                        abort_run("data access outside the data memory");
                    d_delay = int'($unsigned($random(seed)) % 4);
                end
                if (d_delay == 0) begin
                    if (dmem_we)
                        dmem[dmem_addr[5:2]] = dmem_wdata;
                    else
                        dmem_rdata = dmem[dmem_addr[5:2]];
                    dmem_ack = 1'b1;
                end
                d_delay--;
            end
        end
    end

    // outputs settle after the input drive, sample mid cycle
    always @(negedge CLK) begin
        if (!rst) begin
            if (wb_valid)
                obs_q.push_back({4'h1, 23'd0, wb_rd, wb_data}); // older than a trap
            if (trap_valid)
                obs_q.push_back({4'h2, 24'd0, trap_cause, trap_epc});
        end
    end

    initial begin
        for (int i = 0; i < 256; i++)
            pat[i[7:0]] = 32'hfa00_0000 | (32'(i) << 2); // illegal opcode tagged with address
        $readmemh("verification/pipe_patterns.txt", pat);
        for (int i = 0; i < 16; i++)
            dmem[i[3:0]] = pat[8'(DMEM_BASE + i)];

        repeat (2) @(posedge CLK);
        #1;
        check_value("outputs low in reset", 32'd0,
                    {28'd0, imem_req, dmem_req, wb_valid, trap_valid});
        cycles = 0;
        while (rst && cycles < 20) begin
            @(posedge CLK);
            cycles++;
        end
        if (rst)
            abort_run("reset was never released");

        // each expected event against the next observed one
        ev = 0;
        while (ev < MAX_EVENTS && pat[8'(EV_BASE + 2 * ev)] != 32'd0) begin
            cycles = 0;
            while (obs_q.size() == 0 && cycles < EVENT_TIMEOUT) begin
                @(posedge CLK);
                cycles++;
            end
            if (obs_q.size() == 0)
                abort_run($sformatf("no writeback or trap within %0d cycles, event %0d missing",
                                    EVENT_TIMEOUT, ev));
            got = obs_q.pop_front();
            check_value($sformatf("event %0d kind", ev), pat[8'(EV_BASE + 2 * ev)], got[63:32]);
            check_value($sformatf("event %0d value", ev), pat[8'(EV_BASE + 2 * ev + 1)],
                        got[31:0]);
            ev++;
        end

        repeat (DRAIN_CYCLES) @(posedge CLK); // idle loop, nothing more may retire
        check_value("events after the last expected one", 32'd0, obs_q.size());
        if (error_count == 0 && ev > 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            abort_run("pattern file holds no expected events");
        end
    end

endmodule

`default_nettype wire
